/* src/mic_array_config.svh */
`ifndef MIC_ARRAY_CONFIG_SVH
`define MIC_ARRAY_CONFIG_SVH

// microphone data lines on the GPIO header
`define MIC_LINES 16

// left-slot sample width, MSB first
`define SAMPLE_BITS 16

// frames per peak measurement
`define FRAMES_PER_BLOCK 4

// blocks captured after one start
`define BLOCKS_PER_RUN 2

// peak meter input buffer depth
`define STREAM_CREDITS 4

// credits held toward the outside consumer
`define PEAK_CREDITS 2

`endif

/* src/mic_array_pkg.sv */
`include "mic_array_config.svh"

package mic_array_pkg;

	// signed two's-complement audio sample
	typedef logic signed [`SAMPLE_BITS-1:0] sample_t;

	// peak magnitude, sign bit dropped
	typedef logic [`SAMPLE_BITS-2:0] level_t;

	// channel index
	typedef logic [3:0] chan_t;

	// element n holds the sample of line n
	typedef sample_t [`MIC_LINES-1:0] frame_t;

	// run state, also shown on the hex display
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_CAPTURE = 2'd1,
		ST_DONE    = 2'd2
	} run_state_t;

endpackage

/* src/mic_stream_if.sv */
interface mic_stream_if;

	// one channel item per valid cycle
	logic                   valid;
	mic_array_pkg::chan_t   chan;
	mic_array_pkg::sample_t sample;
	// sink returns one credit per popped item
	logic                   credit;

	modport src (
		output valid,
		output chan,
		output sample,
		input  credit
	);

	modport snk (
		input  valid,
		input  chan,
		input  sample,
		output credit
	);

endinterface

/* src/i2s_array_rx.sv */
`include "mic_array_config.svh"

module i2s_array_rx (
	input  logic                  i_50m_clk,
	input  logic                  i_arst_n,
	input  logic                  i_bclk,
	input  logic                  i_lrck,
	input  logic [`MIC_LINES-1:0] i_mic_data,
	output logic                  o_frame_valid,
	output mic_array_pkg::frame_t o_frame
);

	// data sits on bit-clock edges 2 .. SAMPLE_BITS+1 after the word-clock fall
	localparam int LAST_EDGE = `SAMPLE_BITS + 1;
	localparam int CNT_W = $clog2(LAST_EDGE + 1);

	logic [2:0]            bclk_s;
	logic [2:0]            lrck_s;
	logic [`MIC_LINES-1:0] mic_s0;
	logic [`MIC_LINES-1:0] mic_s1;
	logic                  bclk_rise;
	logic                  lrck_fall;
	logic [CNT_W-1:0]      edge_cnt;
	logic                  take_bit;
	logic                  last_bit;
	mic_array_pkg::frame_t shift_q;
	mic_array_pkg::frame_t shift_d;

	// two sync stages, third stage only for edge detection
	always_ff @(posedge i_50m_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			bclk_s <= '0;
			lrck_s <= '0;
			mic_s0 <= '0;
			mic_s1 <= '0;
		end else begin
			bclk_s <= {bclk_s[1:0], i_bclk};
			lrck_s <= {lrck_s[1:0], i_lrck};
			mic_s0 <= i_mic_data;
			mic_s1 <= mic_s0;
		end
	end

	assign bclk_rise = bclk_s[1] & ~bclk_s[2];
	assign lrck_fall = lrck_s[2] & ~lrck_s[1];

	// edge_cnt holds the number of bit-clock rises seen since the word-clock fall
	assign take_bit = bclk_rise && !lrck_fall
		&& edge_cnt >= CNT_W'(1) && edge_cnt <= CNT_W'(`SAMPLE_BITS);
	assign last_bit = bclk_rise && !lrck_fall && edge_cnt == CNT_W'(`SAMPLE_BITS);

	always_ff @(posedge i_50m_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			// parked until the first word-clock fall
			edge_cnt      <= CNT_W'(LAST_EDGE);
			o_frame_valid <= 1'b0;
		end else begin
			o_frame_valid <= last_bit;
			if (lrck_fall) begin
				edge_cnt <= '0;
			end else if (bclk_rise && edge_cnt != CNT_W'(LAST_EDGE)) begin
				edge_cnt <= edge_cnt + 1'b1;
			end
		end
	end

	// shift every line in parallel
	always_comb begin
		shift_d = shift_q;
		if (take_bit) begin
			for (int n = 0; n < `MIC_LINES; n++) begin
				shift_d[n] = {shift_q[n][`SAMPLE_BITS-2:0], mic_s1[n]};
			end
		end
	end

	always_ff @(posedge i_50m_clk) begin
		shift_q <= shift_d;
		// last bit goes straight into the output frame
		if (last_bit) begin
			o_frame <= shift_d;
		end
	end

endmodule

/* src/capture_ctrl.sv */
`include "mic_array_config.svh"

module capture_ctrl (
	input  logic                      i_50m_clk,
	input  logic                      i_arst_n,
	input  logic                      i_start,
	input  logic                      i_frame_valid,
	input  mic_array_pkg::frame_t     i_frame,
	output logic                      o_frame_valid,
	output mic_array_pkg::frame_t     o_frame,
	output mic_array_pkg::run_state_t o_state
);

	localparam int RUN_FRAMES = `FRAMES_PER_BLOCK * `BLOCKS_PER_RUN;
	localparam int CNT_W = $clog2(RUN_FRAMES + 1);

	mic_array_pkg::run_state_t state_q;
	logic [CNT_W-1:0]          frame_cnt;
	logic                      accept;

	assign accept  = state_q == mic_array_pkg::ST_CAPTURE && i_frame_valid;
	assign o_state = state_q;

	always_ff @(posedge i_50m_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q       <= mic_array_pkg::ST_IDLE;
			frame_cnt     <= '0;
			o_frame_valid <= 1'b0;
		end else begin
			o_frame_valid <= accept;
			case (state_q)
				mic_array_pkg::ST_CAPTURE: begin
					if (i_frame_valid) begin
						frame_cnt <= frame_cnt + 1'b1;
						// last frame of the run
						if (frame_cnt == CNT_W'(RUN_FRAMES - 1)) begin
							state_q <= mic_array_pkg::ST_DONE;
						end
					end
				end
				default: begin
					// idle or done, wait for a start request
					if (i_start) begin
						frame_cnt <= '0;
						state_q   <= mic_array_pkg::ST_CAPTURE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_50m_clk) begin
		if (accept) begin
			o_frame <= i_frame;
		end
	end

endmodule

/* src/channel_serializer.sv */
`include "mic_array_config.svh"

module channel_serializer (
	input  logic                  i_50m_clk,
	input  logic                  i_arst_n,
	input  logic                  i_frame_valid,
	input  mic_array_pkg::frame_t i_frame,
	mic_stream_if.src             stream,
	output logic                  o_overrun
);

	localparam int CRD_W = $clog2(`STREAM_CREDITS + 1);

	mic_array_pkg::frame_t frame_q;
	mic_array_pkg::chan_t  chan_q;
	logic                  busy_q;
	logic [CRD_W-1:0]      credits_q;
	logic                  send;
	logic                  last_chan;
	logic                  accept;

	assign send      = busy_q && credits_q != '0;
	assign last_chan = chan_q == mic_array_pkg::chan_t'(`MIC_LINES - 1);
	// held frame is free once its last channel goes out
	assign accept    = i_frame_valid && (!busy_q || (send && last_chan));

	assign stream.valid  = send;
	assign stream.chan   = chan_q;
	assign stream.sample = frame_q[chan_q];

	always_ff @(posedge i_50m_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy_q    <= 1'b0;
			chan_q    <= '0;
			credits_q <= CRD_W'(`STREAM_CREDITS);
			o_overrun <= 1'b0;
		end else begin
			credits_q <= credits_q + CRD_W'(stream.credit) - CRD_W'(send);
			// new frame while the old one is still going out, sticky
			if (i_frame_valid && !accept) begin
				o_overrun <= 1'b1;
			end
			if (accept) begin
				busy_q <= 1'b1;
				chan_q <= '0;
			end else if (send) begin
				chan_q <= chan_q + 1'b1;
				if (last_chan) begin
					busy_q <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge i_50m_clk) begin
		if (accept) begin
			frame_q <= i_frame;
		end
	end

endmodule

/* src/peak_meter.sv */
`include "mic_array_config.svh"

module peak_meter (
	input  logic                  i_50m_clk,
	input  logic                  i_arst_n,
	mic_stream_if.snk             stream,
	input  logic                  i_peak_credit,
	output logic                  o_peak_valid,
	output mic_array_pkg::chan_t  o_peak_chan,
	output mic_array_pkg::level_t o_peak_level
);

	localparam int DEPTH = `STREAM_CREDITS;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int PCRD_W = $clog2(`PEAK_CREDITS + 1);
	localparam int FRM_W = $clog2(`FRAMES_PER_BLOCK + 1);
	localparam mic_array_pkg::chan_t LAST_CHAN = mic_array_pkg::chan_t'(`MIC_LINES - 1);

	mic_array_pkg::chan_t   buf_chan [DEPTH];
	mic_array_pkg::sample_t buf_sample [DEPTH];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [CNT_W-1:0]       fill_q;
	logic                   credit_q;
	logic                   pop;
	mic_array_pkg::chan_t   pop_chan;
	mic_array_pkg::sample_t pop_sample;
	mic_array_pkg::level_t  pop_mag;
	mic_array_pkg::level_t  peak_q [`MIC_LINES];
	logic [`MIC_LINES-1:0]  first_q;
	logic [FRM_W-1:0]       frame_cnt;
	logic                   block_end;
	logic                   emit_q;
	mic_array_pkg::chan_t   out_chan;
	logic [PCRD_W-1:0]      pcred_q;
	logic                   peak_send;

	// no popping while block results are going out
	assign pop        = fill_q != '0 && !emit_q;
	assign pop_chan   = buf_chan[rd_ptr];
	assign pop_sample = buf_sample[rd_ptr];
	assign block_end  = pop && pop_chan == LAST_CHAN
		&& frame_cnt == FRM_W'(`FRAMES_PER_BLOCK - 1);

	assign stream.credit = credit_q;

	assign peak_send    = emit_q && pcred_q != '0;
	assign o_peak_valid = peak_send;
	assign o_peak_chan  = out_chan;
	assign o_peak_level = peak_q[out_chan];

	// magnitude, -full scale clips to the top level
	always_comb begin
		mic_array_pkg::sample_t neg_s;
		neg_s = -pop_sample;
		if (pop_sample == {1'b1, {(`SAMPLE_BITS-1){1'b0}}}) begin
			pop_mag = '1;
		end else if (pop_sample[`SAMPLE_BITS-1]) begin
			pop_mag = neg_s[`SAMPLE_BITS-2:0];
		end else begin
			pop_mag = pop_sample[`SAMPLE_BITS-2:0];
		end
	end

	always_ff @(posedge i_50m_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			fill_q    <= '0;
			credit_q  <= 1'b0;
			first_q   <= '1;
			frame_cnt <= '0;
			emit_q    <= 1'b0;
			out_chan  <= '0;
			pcred_q   <= PCRD_W'(`PEAK_CREDITS);
		end else begin
			credit_q <= pop;
			fill_q   <= fill_q + CNT_W'(stream.valid) - CNT_W'(pop);
			pcred_q  <= pcred_q + PCRD_W'(i_peak_credit) - PCRD_W'(peak_send);
			if (stream.valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
				first_q[pop_chan] <= 1'b0;
				// channel 15 closes a frame
				if (pop_chan == LAST_CHAN) begin
					frame_cnt <= block_end ? '0 : frame_cnt + 1'b1;
				end
			end
			if (block_end) begin
				emit_q   <= 1'b1;
				out_chan <= '0;
			end else if (peak_send) begin
				out_chan <= out_chan + 1'b1;
				if (out_chan == LAST_CHAN) begin
					emit_q  <= 1'b0;
					first_q <= '1;
				end
			end
		end
	end

	always_ff @(posedge i_50m_clk) begin
		if (stream.valid) begin
			buf_chan[wr_ptr]   <= stream.chan;
			buf_sample[wr_ptr] <= stream.sample;
		end
		// first sample of a block always loads
		if (pop && (first_q[pop_chan] || pop_mag > peak_q[pop_chan])) begin
			peak_q[pop_chan] <= pop_mag;
		end
	end

endmodule

/* src/mic_array_top.sv */
`include "mic_array_config.svh"

module mic_array_top (
	input  logic                      i_50m_clk,
	input  logic                      i_arst_n,
	input  logic                      i_bclk,
	input  logic                      i_lrck,
	input  logic [`MIC_LINES-1:0]     i_mic_data,
	input  logic                      i_start,
	input  logic                      i_peak_credit,
	output logic                      o_peak_valid,
	output mic_array_pkg::chan_t      o_peak_chan,
	output mic_array_pkg::level_t     o_peak_level,
	output logic                      o_overrun,
	output mic_array_pkg::run_state_t o_state
);

	logic                  rx_frame_valid;
	mic_array_pkg::frame_t rx_frame;
	logic                  cap_frame_valid;
	mic_array_pkg::frame_t cap_frame;

	mic_stream_if stream_if ();

	i2s_array_rx u_rx (
		.i_50m_clk     (i_50m_clk),
		.i_arst_n      (i_arst_n),
		.i_bclk        (i_bclk),
		.i_lrck        (i_lrck),
		.i_mic_data    (i_mic_data),
		.o_frame_valid (rx_frame_valid),
		.o_frame       (rx_frame)
	);

	// frames only pass during a run
	capture_ctrl u_ctrl (
		.i_50m_clk     (i_50m_clk),
		.i_arst_n      (i_arst_n),
		.i_start       (i_start),
		.i_frame_valid (rx_frame_valid),
		.i_frame       (rx_frame),
		.o_frame_valid (cap_frame_valid),
		.o_frame       (cap_frame),
		.o_state       (o_state)
	);

	channel_serializer u_ser (
		.i_50m_clk     (i_50m_clk),
		.i_arst_n      (i_arst_n),
		.i_frame_valid (cap_frame_valid),
		.i_frame       (cap_frame),
		.stream        (stream_if),
		.o_overrun     (o_overrun)
	);

	peak_meter u_peak (
		.i_50m_clk     (i_50m_clk),
		.i_arst_n      (i_arst_n),
		.stream        (stream_if),
		.i_peak_credit (i_peak_credit),
		.o_peak_valid  (o_peak_valid),
		.o_peak_chan   (o_peak_chan),
		.o_peak_level  (o_peak_level)
	);

endmodule

/* tests/tb_mic_array.sv */
`include "mic_array_config.svh"

module tb_mic_array;

	localparam int RUN_FRAMES = `FRAMES_PER_BLOCK * `BLOCKS_PER_RUN;
	localparam int TIMEOUT = 6000;

	logic                      i_50m_clk;
	logic                      i_arst_n;
	logic                      i_bclk;
	logic                      i_lrck;
	logic [`MIC_LINES-1:0]     i_mic_data;
	logic                      i_start;
	logic                      i_peak_credit;
	logic                      o_peak_valid;
	mic_array_pkg::chan_t      o_peak_chan;
	mic_array_pkg::level_t     o_peak_level;
	logic                      o_overrun;
	mic_array_pkg::run_state_t o_state;

	mic_array_pkg::sample_t stim [RUN_FRAMES][`MIC_LINES];
	mic_array_pkg::level_t  exp_peak [`BLOCKS_PER_RUN][`MIC_LINES];
	mic_array_pkg::chan_t   got_chan [$];
	mic_array_pkg::level_t  got_level [$];
	logic [31:0]            lfsr_q;
	logic                   hold_credits;
	int                     owed;
	int                     errors;
	int                     timeouts;

	mic_array_top DUT (
		.i_50m_clk     (i_50m_clk),
		.i_arst_n      (i_arst_n),
		.i_bclk        (i_bclk),
		.i_lrck        (i_lrck),
		.i_mic_data    (i_mic_data),
		.i_start       (i_start),
		.i_peak_credit (i_peak_credit),
		.o_peak_valid  (o_peak_valid),
		.o_peak_chan   (o_peak_chan),
		.o_peak_level  (o_peak_level),
		.o_overrun     (o_overrun),
		.o_state       (o_state)
	);

	initial begin
		i_50m_clk = 1'b0;
		forever begin
			#4 i_50m_clk = ~i_50m_clk;
		end
	end

	// fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// absolute value clipped to the largest level
	function automatic mic_array_pkg::level_t magnitude(input mic_array_pkg::sample_t s);
		int v;
		v = int'(s);
		if (v < 0) begin
			v = -v;
		end
		if (v > (1 << (`SAMPLE_BITS - 1)) - 1) begin
			v = (1 << (`SAMPLE_BITS - 1)) - 1;
		end
		return mic_array_pkg::level_t'(v);
	endfunction

	task automatic fill_table();
		mic_array_pkg::sample_t corner [5];
		mic_array_pkg::sample_t v;
		mic_array_pkg::level_t  m;
		// 0, 1, -1, +full scale, -full scale
		corner[0] = 16'h0000;
		corner[1] = 16'h0001;
		corner[2] = 16'hffff;
		corner[3] = 16'h7fff;
		corner[4] = 16'h8000;
		lfsr_q = 32'h5fc2;
		for (int f = 0; f < RUN_FRAMES; f++) begin
			for (int n = 0; n < `MIC_LINES; n++) begin
				if (n < 5) begin
					stim[f][n] = corner[(n + f) % 5];
				end else begin
					v = '0;
					for (int b = 0; b < `SAMPLE_BITS; b++) begin
						lfsr_q = lfsr_next(lfsr_q);
						v = {v[`SAMPLE_BITS-2:0], lfsr_q[0]};
					end
					stim[f][n] = v;
				end
			end
		end
		for (int blk = 0; blk < `BLOCKS_PER_RUN; blk++) begin
			for (int ch = 0; ch < `MIC_LINES; ch++) begin
				exp_peak[blk][ch] = '0;
				for (int k = 0; k < `FRAMES_PER_BLOCK; k++) begin
					m = magnitude(stim[blk * `FRAMES_PER_BLOCK + k][ch]);
					if (m > exp_peak[blk][ch]) begin
						exp_peak[blk][ch] = m;
					end
				end
			end
		end
	endtask

	// one word-clock period carrying the left slot from the table
	task automatic send_frame(input int f);
		mic_array_pkg::sample_t s;
		for (int half = 0; half < 2; half++) begin
			for (int b = 0; b < 32; b++) begin
				@(negedge i_50m_clk);
				i_lrck = (half == 1);
				i_bclk = 1'b0;
				for (int n = 0; n < `MIC_LINES; n++) begin
					s = stim[f][n];
					i_mic_data[n] = (half == 0 && b >= 1 && b <= `SAMPLE_BITS)
						? s[`SAMPLE_BITS - b] : 1'b0;
				end
				repeat (4) @(negedge i_50m_clk);
				i_bclk = 1'b1;
				repeat (3) @(negedge i_50m_clk);
			end
		end
	endtask

	task automatic send_frames();
		for (int f = 0; f < RUN_FRAMES; f++) begin
			send_frame(f);
		end
	endtask

	task automatic pulse_start();
		@(negedge i_50m_clk);
		i_start = 1'b1;
		@(negedge i_50m_clk);
		i_start = 1'b0;
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	task automatic check_level(input mic_array_pkg::level_t got,
			input mic_array_pkg::level_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_chan(input mic_array_pkg::chan_t got,
			input mic_array_pkg::chan_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_state(input mic_array_pkg::run_state_t got,
			input mic_array_pkg::run_state_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %s expected %s", $time, what,
				got.name(), exp.name());
			errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic wait_state(input mic_array_pkg::run_state_t s);
		int cycles;
		cycles = 0;
		while (o_state != s && cycles < 20) begin
			@(negedge i_50m_clk);
			cycles++;
		end
		if (o_state != s) begin
			$display("timed out waiting for state %s", s.name());
			timeouts++;
			finish_run();
		end
	endtask

	// results are queued on falling edges
	task automatic wait_results(input int n);
		int cycles;
		cycles = 0;
		while (got_level.size() < n && cycles < TIMEOUT) begin
			@(posedge i_50m_clk);
			cycles++;
		end
		if (got_level.size() < n) begin
			$display("timed out waiting for %0d results, %0d arrived", n, got_level.size());
			timeouts++;
			finish_run();
		end
	endtask

	// every received result has its credit back in the DUT
	task automatic wait_credits_back();
		int cycles;
		cycles = 0;
		while (owed != 0 && cycles < 20) begin
			@(posedge i_50m_clk);
			cycles++;
		end
		if (owed != 0) begin
			$display("timed out waiting for %0d peak credits to go back", owed);
			timeouts++;
			finish_run();
		end
	endtask

	task automatic verify_results(input int base, input int count);
		int idx;
		for (int i = 0; i < count; i++) begin
			idx = base + i;
			check_chan(got_chan[idx], mic_array_pkg::chan_t'(i % `MIC_LINES),
				$sformatf("channel of result %0d", idx));
			check_level(got_level[idx], exp_peak[i / `MIC_LINES][i % `MIC_LINES],
				$sformatf("level of result %0d", idx));
		end
	endtask

	// result consumer returns one credit per result unless held
	initial begin
		i_peak_credit = 1'b0;
		owed = 0;
		forever begin
			@(negedge i_50m_clk);
			i_peak_credit = 1'b0;
			if (owed > 0 && !hold_credits) begin
				i_peak_credit = 1'b1;
				owed--;
			end
			if (o_peak_valid) begin
				got_chan.push_back(o_peak_chan);
				got_level.push_back(o_peak_level);
				owed++;
			end
		end
	end

	initial begin
		int base;
		errors = 0;
		timeouts = 0;
		hold_credits = 1'b0;
		i_arst_n = 1'b0;
		i_bclk = 1'b0;
		i_lrck = 1'b1;
		i_mic_data = '0;
		i_start = 1'b0;
		base = 0;
		fill_table();
		repeat (2) @(negedge i_50m_clk);
		i_arst_n = 1'b1;
		@(negedge i_50m_clk);

		// idle after reset and frames ignored
		check_state(o_state, mic_array_pkg::ST_IDLE, "state after reset");
		check_flag(o_peak_valid, 1'b0, "peak valid after reset");
		check_flag(o_overrun, 1'b0, "overrun after reset");
		send_frames();
		repeat (100) @(posedge i_50m_clk);
		check_count(got_level.size(), 0, "results before start");

		// one full run of two blocks
		pulse_start();
		wait_state(mic_array_pkg::ST_CAPTURE);
		send_frames();
		wait_results(32);
		verify_results(base, 32);
		base += 32;
		@(negedge i_50m_clk);
		check_state(o_state, mic_array_pkg::ST_DONE, "state after run");

		// no more results once done
		send_frames();
		repeat (100) @(posedge i_50m_clk);
		check_count(got_level.size() - base, 0, "results after run end");

		// short credit stall
		hold_credits = 1'b1;
		pulse_start();
		wait_state(mic_array_pkg::ST_CAPTURE);
		fork
			send_frames();
			begin
				wait_results(base + `PEAK_CREDITS);
				// next frame backs up into the serializer before the release
				repeat (600) @(posedge i_50m_clk);
				check_count(got_level.size() - base, `PEAK_CREDITS,
					"results with credits withheld");
				hold_credits = 1'b0;
			end
		join
		wait_results(base + 32);
		verify_results(base, 32);
		base += 32;
		@(negedge i_50m_clk);
		check_flag(o_overrun, 1'b0, "overrun after short stall");
		check_state(o_state, mic_array_pkg::ST_DONE, "state after stalled run");

		// long stall drops the later frames
		wait_credits_back();
		hold_credits = 1'b1;
		pulse_start();
		wait_state(mic_array_pkg::ST_CAPTURE);
		send_frames();
		check_count(got_level.size() - base, `PEAK_CREDITS, "results during long stall");
		@(negedge i_50m_clk);
		check_flag(o_overrun, 1'b1, "overrun after long stall");
		hold_credits = 1'b0;
		wait_results(base + `MIC_LINES);
		repeat (200) @(posedge i_50m_clk);
		check_count(got_level.size() - base, `MIC_LINES, "results of overrun run");
		verify_results(base, `MIC_LINES);
		@(negedge i_50m_clk);
		check_flag(o_overrun, 1'b1, "overrun stays set");
		finish_run();
	end

endmodule

/* mic_array.f */
+incdir+src
src/mic_array_pkg.sv
src/mic_stream_if.sv
src/i2s_array_rx.sv
src/capture_ctrl.sv
src/channel_serializer.sv
src/peak_meter.sv
src/mic_array_top.sv
tests/tb_mic_array.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f mic_array.f --top-module tb_mic_array
out=$(./obj_dir/Vtb_mic_array)
echo "$out"
if echo "$out" | grep -qx "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
